// File: soc_pkg.sv
package soc_pkg;

  // Bus widths
  localparam int DATA_W = 16;
  localparam int ADR_W  = 19;

  // I/O port of the LED register, found in byte-address bits 15 to 8
  localparam logic [7:0] LED_PORT = 8'hf1;

  // Read value for anything that has no slave behind it
  localparam logic [DATA_W-1:0] UNMAPPED_DATA = {DATA_W{1'b1}};

  // Segments of byte-address bits 19 to 16 that map to the flash window
  localparam logic [3:0] FLASH_SEG_C = 4'hc;
  localparam logic [3:0] FLASH_SEG_F = 4'hf;

  // Word-address bit that carries byte-address bit 18 (SRAM when low)
  localparam int SRAM_SEL_BIT = 17;

  // Region of a processor request
  typedef enum logic [1:0] {
    ARENA_FLASH,
    ARENA_SRAM,
    ARENA_IO,
    ARENA_NONE
  } arena_e;

endpackage

// File: bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder import soc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_stb_i,
  input  logic              req_we_i,
  input  logic              req_io_i,
  input  logic [ADR_W-1:0]  req_adr_i,
  input  logic [1:0]        req_sel_i,
  input  logic [DATA_W-1:0] req_dat_i,
  output logic              flash_stb_o,
  output logic              sram_stb_o,
  output logic              take_o,
  output arena_e            take_arena_o,
  output logic [DATA_W-1:0] io_rdata_o,
  output logic [DATA_W-1:0] leds_o
);

  logic [3:0]        seg;
  logic [7:0]        io_port;
  logic              flash_seg;
  logic              led_hit;
  logic              led_wr;
  arena_e            arena;
  logic [DATA_W-1:0] leds_q;

  // Byte-address bits 19:16 sit at word-address bits 18:15
  assign seg     = req_adr_i[ADR_W-1 -: 4];
  // Port number in byte-address bits 15:8
  assign io_port = req_adr_i[14:7];

  assign flash_seg = (seg == FLASH_SEG_C) || (seg == FLASH_SEG_F);

  always_comb begin
    if (req_io_i) begin
      arena = ARENA_IO;
    end else if (flash_seg) begin
      // Flash is read only, writes fall through to unmapped
      arena = req_we_i ? ARENA_NONE : ARENA_FLASH;
    end else if (!req_adr_i[SRAM_SEL_BIT]) begin
      arena = ARENA_SRAM;
    end else begin
      arena = ARENA_NONE;
    end
  end

  assign flash_stb_o  = req_stb_i && (arena == ARENA_FLASH);
  assign sram_stb_o   = req_stb_i && (arena == ARENA_SRAM);
  assign take_o       = req_stb_i;
  assign take_arena_o = arena;

  assign led_hit = req_io_i && (io_port == LED_PORT);
  assign led_wr  = req_stb_i && req_we_i && led_hit;

  // LED register, byte-lane writes
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      leds_q <= '0;
    end else if (led_wr) begin
      for (int b = 0; b < 2; b++) begin
        if (req_sel_i[b]) begin
          leds_q[8*b +: 8] <= req_dat_i[8*b +: 8];
        end
      end
    end
  end

  // Other ports read as zero
  assign io_rdata_o = led_hit ? leds_q : '0;
  assign leds_o     = leds_q;

endmodule

// File: flash_reader.sv
`timescale 1ns/1ns

module flash_reader import soc_pkg::*; #(
  parameter int FLASH_WAIT = 2
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              stb_i,
  input  logic [ADR_W-1:0]  adr_i,
  input  logic [7:0]        flash_data_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [16:0]       flash_addr_o,
  output logic              flash_oe_n_o
);

  localparam int CNT_W = (FLASH_WAIT > 0) ? $clog2(FLASH_WAIT + 1) : 1;

  typedef enum logic [1:0] {
    FR_IDLE,
    FR_LOW,
    FR_HIGH
  } fr_state_e;

  fr_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             slot_end;
  logic [15:0]      word_q;
  logic [7:0]       lo_q;

  // Last cycle of a byte slot
  assign slot_end = (cnt_q == CNT_W'(FLASH_WAIT));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FR_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        FR_IDLE: begin
          if (stb_i) begin
            state_q <= FR_LOW;
            cnt_q   <= '0;
          end
        end
        FR_LOW: begin
          if (slot_end) begin
            state_q <= FR_HIGH;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        FR_HIGH: begin
          if (slot_end) begin
            state_q <= FR_IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= FR_IDLE;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  // Word address and even byte
  always_ff @(posedge clk) begin
    if (state_q == FR_IDLE && stb_i) begin
      word_q <= adr_i[15:0];
    end
    if (state_q == FR_LOW && slot_end) begin
      lo_q <= flash_data_i;
    end
  end

  assign flash_addr_o = {word_q, state_q == FR_HIGH};
  assign flash_oe_n_o = (state_q == FR_IDLE);

  // Odd byte is taken straight off the pads at the end of its slot
  assign ack_o   = (state_q == FR_HIGH) && slot_end;
  assign rdata_o = {flash_data_i, lo_q};

  // Decoder keeps one request outstanding, so the reader is idle on a strobe
  a_stb_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    stb_i |-> state_q == FR_IDLE);

endmodule

// File: sram_arbiter.sv
`timescale 1ns/1ns

module sram_arbiter import soc_pkg::*; #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              cpu_stb_i,
  input  logic              cpu_we_i,
  input  logic [RAM_AW-1:0] cpu_adr_i,
  input  logic [1:0]        cpu_sel_i,
  input  logic [DATA_W-1:0] cpu_dat_i,
  input  logic              disp_stb_i,
  input  logic [RAM_AW-2:0] disp_adr_i,
  output logic              cpu_ack_o,
  output logic [DATA_W-1:0] cpu_rdata_o,
  output logic              disp_ack_o,
  output logic [DATA_W-1:0] disp_dat_o
);

  logic [DATA_W-1:0] mem [2**RAM_AW];

  // Control state
  logic pend_q;
  logic disp_hold_q;

  // Pending cpu slot and held display address
  logic              pend_we_q;
  logic [RAM_AW-1:0] pend_adr_q;
  logic [1:0]        pend_sel_q;
  logic [DATA_W-1:0] pend_dat_q;
  logic [RAM_AW-2:0] disp_adr_q;

  logic              disp_req;
  logic              serve_disp;
  logic              serve_cpu;
  logic              acc_we;
  logic [RAM_AW-1:0] acc_adr;
  logic [1:0]        acc_sel;
  logic [DATA_W-1:0] acc_dat;
  logic [RAM_AW-2:0] disp_adr;
  logic [RAM_AW-1:0] mem_adr;
  logic [DATA_W-1:0] rd_q;

  assign disp_req = disp_stb_i || disp_hold_q;

  // Slot first, then display, then a fresh cpu strobe
  assign serve_disp = !pend_q && disp_req;
  assign serve_cpu  = pend_q || (!disp_req && cpu_stb_i);

  assign acc_we  = pend_q ? pend_we_q  : cpu_we_i;
  assign acc_adr = pend_q ? pend_adr_q : cpu_adr_i;
  assign acc_sel = pend_q ? pend_sel_q : cpu_sel_i;
  assign acc_dat = pend_q ? pend_dat_q : cpu_dat_i;

  // Display window is the upper half of the array
  assign disp_adr = disp_hold_q ? disp_adr_q : disp_adr_i;
  assign mem_adr  = serve_disp ? {1'b1, disp_adr} : acc_adr;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q      <= 1'b0;
      disp_hold_q <= 1'b0;
      cpu_ack_o   <= 1'b0;
      disp_ack_o  <= 1'b0;
    end else begin
      pend_q      <= !pend_q && disp_req && cpu_stb_i;
      disp_hold_q <= pend_q && disp_stb_i;
      cpu_ack_o   <= serve_cpu;
      disp_ack_o  <= serve_disp;
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_stb_i && !pend_q) begin
      pend_we_q  <= cpu_we_i;
      pend_adr_q <= cpu_adr_i;
      pend_sel_q <= cpu_sel_i;
      pend_dat_q <= cpu_dat_i;
    end
    if (disp_stb_i) begin
      disp_adr_q <= disp_adr_i;
    end
  end

  // Single port, one access per cycle
  always_ff @(posedge clk) begin
    if (serve_cpu && acc_we) begin
      for (int b = 0; b < 2; b++) begin
        if (acc_sel[b]) begin
          mem[mem_adr][8*b +: 8] <= acc_dat[8*b +: 8];
        end
      end
    end
    rd_q <= mem[mem_adr];
  end

  assign cpu_rdata_o = rd_q;
  assign disp_dat_o  = rd_q;

  // One outstanding cpu request; display strobes spaced by two cycles
  a_no_stb_pend: assert property (@(posedge clk) disable iff (!arst_n_i)
    cpu_stb_i |-> !pend_q);
  a_no_disp_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    disp_stb_i |-> !disp_hold_q);

endmodule

// File: response_combiner.sv
`timescale 1ns/1ns

module response_combiner import soc_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              take_i,
  input  arena_e            take_arena_i,
  input  logic [DATA_W-1:0] io_rdata_i,
  input  logic              flash_ack_i,
  input  logic [DATA_W-1:0] flash_rdata_i,
  input  logic              sram_ack_i,
  input  logic [DATA_W-1:0] sram_rdata_i,
  output logic              rsp_ack_o,
  output logic [DATA_W-1:0] rsp_dat_o
);

  arena_e arena_q;
  logic   busy_q;
  logic   take_slave;
  logic   flash_hit;
  logic   sram_hit;

  // Flash and SRAM answer later, the rest answer at once
  assign take_slave = (take_arena_i == ARENA_FLASH) || (take_arena_i == ARENA_SRAM);

  assign flash_hit = busy_q && (arena_q == ARENA_FLASH) && flash_ack_i;
  assign sram_hit  = busy_q && (arena_q == ARENA_SRAM) && sram_ack_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arena_q   <= ARENA_NONE;
      busy_q    <= 1'b0;
      rsp_ack_o <= 1'b0;
    end else begin
      rsp_ack_o <= 1'b0;
      if (take_i) begin
        arena_q   <= take_arena_i;
        busy_q    <= take_slave;
        rsp_ack_o <= !take_slave;
      end else if (flash_hit || sram_hit) begin
        busy_q    <= 1'b0;
        rsp_ack_o <= 1'b1;
      end
    end
  end

  // Reply data of the awaited source
  always_ff @(posedge clk) begin
    if (take_i) begin
      rsp_dat_o <= (take_arena_i == ARENA_IO) ? io_rdata_i : UNMAPPED_DATA;
    end else if (flash_hit) begin
      rsp_dat_o <= flash_rdata_i;
    end else if (sram_hit) begin
      rsp_dat_o <= sram_rdata_i;
    end
  end

  a_take_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    take_i |-> !busy_q);

  // A slave only answers the region the decoder sent it
  a_flash_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
    flash_ack_i |-> busy_q && arena_q == ARENA_FLASH);
  a_sram_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
    sram_ack_i |-> busy_q && arena_q == ARENA_SRAM);

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top import soc_pkg::*; #(
  parameter int FLASH_WAIT = 2,
  parameter int RAM_AW     = 10
) (
  input  logic              clk,
  input  logic              arst_n_i,
  // Processor request
  input  logic              req_stb_i,
  input  logic              req_we_i,
  input  logic              req_io_i,
  input  logic [ADR_W-1:0]  req_adr_i,
  input  logic [1:0]        req_sel_i,
  input  logic [DATA_W-1:0] req_dat_i,
  output logic              rsp_ack_o,
  output logic [DATA_W-1:0] rsp_dat_o,
  // Display fetch port
  input  logic              disp_stb_i,
  input  logic [RAM_AW-2:0] disp_adr_i,
  output logic              disp_ack_o,
  output logic [DATA_W-1:0] disp_dat_o,
  // Flash pads
  input  logic [7:0]        flash_data_i,
  output logic [16:0]       flash_addr_o,
  output logic              flash_oe_n_o,
  output logic [DATA_W-1:0] leds_o
);

  logic              flash_stb;
  logic              sram_stb;
  logic              req_take;
  arena_e            take_arena;
  logic [DATA_W-1:0] io_rsp;
  logic              flash_ack;
  logic [DATA_W-1:0] flash_rdata;
  logic              sram_ack;
  logic [DATA_W-1:0] sram_rdata;

  bus_decoder bus_decoder_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_stb_i    (req_stb_i),
    .req_we_i     (req_we_i),
    .req_io_i     (req_io_i),
    .req_adr_i    (req_adr_i),
    .req_sel_i    (req_sel_i),
    .req_dat_i    (req_dat_i),
    .flash_stb_o  (flash_stb),
    .sram_stb_o   (sram_stb),
    .take_o       (req_take),
    .take_arena_o (take_arena),
    .io_rdata_o   (io_rsp),
    .leds_o       (leds_o)
  );

  flash_reader #(
    .FLASH_WAIT (FLASH_WAIT)
  ) flash_reader_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .stb_i        (flash_stb),
    .adr_i        (req_adr_i),
    .flash_data_i (flash_data_i),
    .ack_o        (flash_ack),
    .rdata_o      (flash_rdata),
    .flash_addr_o (flash_addr_o),
    .flash_oe_n_o (flash_oe_n_o)
  );

  // SRAM is indexed by the low word-address bits
  sram_arbiter #(
    .RAM_AW (RAM_AW)
  ) sram_arbiter_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cpu_stb_i   (sram_stb),
    .cpu_we_i    (req_we_i),
    .cpu_adr_i   (req_adr_i[RAM_AW-1:0]),
    .cpu_sel_i   (req_sel_i),
    .cpu_dat_i   (req_dat_i),
    .disp_stb_i  (disp_stb_i),
    .disp_adr_i  (disp_adr_i),
    .cpu_ack_o   (sram_ack),
    .cpu_rdata_o (sram_rdata),
    .disp_ack_o  (disp_ack_o),
    .disp_dat_o  (disp_dat_o)
  );

  response_combiner response_combiner_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .take_i        (req_take),
    .take_arena_i  (take_arena),
    .io_rdata_i    (io_rsp),
    .flash_ack_i   (flash_ack),
    .flash_rdata_i (flash_rdata),
    .sram_ack_i    (sram_ack),
    .sram_rdata_i  (sram_rdata),
    .rsp_ack_o     (rsp_ack_o),
    .rsp_dat_o     (rsp_dat_o)
  );

endmodule

// File: tb_soc_bus.sv
`timescale 1ns/1ns

module tb_soc_bus import soc_pkg::*;;

  localparam int          CLK_PERIOD  = 4;
  localparam int          RESET_CYC   = 16;
  localparam int          PAT_CNT     = 22;
  localparam int          TIMEOUT_CYC = PAT_CNT * 16 + RESET_CYC;
  localparam logic [31:0] LFSR_SEED   = 32'hf863_1f75;
  localparam int          FLASH_WAIT  = 2;
  localparam int          RAM_AW      = 10;

  logic              clk;
  logic              arst_n_i;
  logic              req_stb_i;
  logic              req_we_i;
  logic              req_io_i;
  logic [ADR_W-1:0]  req_adr_i;
  logic [1:0]        req_sel_i;
  logic [DATA_W-1:0] req_dat_i;
  logic              rsp_ack_o;
  logic [DATA_W-1:0] rsp_dat_o;
  logic              disp_stb_i;
  logic [RAM_AW-2:0] disp_adr_i;
  logic              disp_ack_o;
  logic [DATA_W-1:0] disp_dat_o;
  logic [7:0]        flash_data_i;
  logic [16:0]       flash_addr_o;
  logic              flash_oe_n_o;
  logic [DATA_W-1:0] leds_o;

  // Six fields per request: we, io, adr, sel, wdat, exp
  logic [19:0]       pat_mem [PAT_CNT*6];
  logic [DATA_W-1:0] shadow [2**(RAM_AW-1)];
  bit                shadow_ok [2**(RAM_AW-1)];
  logic [DATA_W-1:0] led_model = '0;
  logic [31:0]       lfsr_q = LFSR_SEED;
  logic              player_done = 1'b0;
  logic              disp_done = 1'b0;
  int                cycle_cnt = 0;

  soc_bus_top #(
    .FLASH_WAIT (FLASH_WAIT),
    .RAM_AW     (RAM_AW)
  ) soc_bus_top_i (.*);

  // Flash device model
  assign flash_data_i = flash_addr_o[7:0] ^ flash_addr_o[15:8];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping on the first mismatch");
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // Memory map by byte-address bits 19:16 (word bits 18:15)
  function automatic arena_e region_of(input logic we, input logic io, input logic [18:0] adr);
    if (io) return ARENA_IO;
    if (adr[18:15] == 4'hc || adr[18:15] == 4'hf) return we ? ARENA_NONE : ARENA_FLASH;
    if (!adr[17]) return ARENA_SRAM;
    return ARENA_NONE;
  endfunction

  task automatic run_request(input int n);
    logic        we;
    logic        io;
    logic [18:0] adr;
    logic [1:0]  sel;
    logic [15:0] wdat;
    logic [15:0] exp;
    arena_e      arena;
    logic        collide;
    int          lat;
    int          exp_lat;
    we    = pat_mem[6*n][0];
    io    = pat_mem[6*n+1][0];
    adr   = pat_mem[6*n+2][18:0];
    sel   = pat_mem[6*n+3][1:0];
    wdat  = pat_mem[6*n+4][15:0];
    exp   = pat_mem[6*n+5][15:0];
    arena = region_of(we, io, adr);
    @(posedge clk);
    req_stb_i <= 1'b1;
    req_we_i  <= we;
    req_io_i  <= io;
    req_adr_i <= adr;
    req_sel_i <= sel;
    req_dat_i <= wdat;
    // Display strobe seen by the DUT in the same cycle as this request
    @(negedge clk);
    collide = disp_stb_i;
    @(posedge clk);
    req_stb_i <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      // Output enable stays low through both byte slots
      if (arena == ARENA_FLASH) begin
        compare_value("flash_oe_n_o", flash_oe_n_o, lat > 2 * (FLASH_WAIT + 1));
      end
    end while (!rsp_ack_o);
    case (arena)
      ARENA_FLASH: exp_lat = 2 * FLASH_WAIT + 3;
      ARENA_SRAM:  exp_lat = collide ? 3 : 2;
      default:     exp_lat = 1;
    endcase
    compare_value("rsp_ack_o latency", lat, exp_lat);
    if (!we || arena == ARENA_NONE) compare_value("rsp_dat_o", rsp_dat_o, exp);
    for (int b = 0; b < 2; b++) begin
      if (we && sel[b] && arena == ARENA_IO && adr[14:7] == LED_PORT) begin
        led_model[8*b +: 8] = wdat[8*b +: 8];
      end
      if (we && sel[b] && arena == ARENA_SRAM && adr[RAM_AW-1]) begin
        shadow[adr[RAM_AW-2:0]][8*b +: 8] = wdat[8*b +: 8];
      end
    end
    if (we && arena == ARENA_SRAM && adr[RAM_AW-1]) shadow_ok[adr[RAM_AW-2:0]] = 1'b1;
    compare_value("leds_o", leds_o, led_model);
  endtask

  initial begin : player
    arst_n_i   = 1'b0;
    req_stb_i  = 1'b0;
    req_we_i   = 1'b0;
    req_io_i   = 1'b0;
    req_adr_i  = '0;
    req_sel_i  = '0;
    req_dat_i  = '0;
    disp_stb_i = 1'b0;
    disp_adr_i = '0;
    $readmemh("soc_patterns.hex", pat_mem);
    repeat (RESET_CYC) @(posedge clk);
    arst_n_i <= 1'b1;
    // Quiet bus after reset
    repeat (4) begin
      @(negedge clk);
      compare_value("rsp_ack_o", rsp_ack_o, 1'b0);
      compare_value("disp_ack_o", disp_ack_o, 1'b0);
    end
    compare_value("leds_o", leds_o, 16'h0000);
    compare_value("flash_oe_n_o", flash_oe_n_o, 1'b1);
    for (int n = 0; n < PAT_CNT; n++) begin
      run_request(n);
    end
    player_done = 1'b1;
    wait (disp_done);
    repeat (2) @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Random display fetches from the preloaded window
  initial begin : display_driver
    logic       go;
    logic [1:0] pick;
    wait (arst_n_i);
    while (!player_done) begin
      @(posedge clk);
      draw_bit(go);
      draw_bit(pick[0]);
      draw_bit(pick[1]);
      if (go && shadow_ok[pick]) begin
        disp_stb_i <= 1'b1;
        disp_adr_i <= {{(RAM_AW-3){1'b0}}, pick};
        @(posedge clk);
        disp_stb_i <= 1'b0;
        @(negedge clk);
        // One extra cycle when a held cpu request goes first
        if (!disp_ack_o) @(negedge clk);
        compare_value("disp_ack_o", disp_ack_o, 1'b1);
        compare_value("disp_dat_o", disp_dat_o, shadow[pick]);
      end
    end
    disp_done = 1'b1;
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: no response arrived within %0d cycles", TIMEOUT_CYC);
    $display("SOME TESTS FAILED");
    $fatal(1, "cycle limit reached");
  end

endmodule

// File: soc_patterns.hex
// we io adr sel wdat exp (hex, one request per line)
// exp is checked on reads and on unmapped replies
1 0 00200 3 1111 0000
1 0 00201 3 2222 0000
1 0 00202 3 a5c3 0000
1 0 00203 3 0ff0 0000
1 0 00010 3 1234 0000
1 0 00011 3 5678 0000
1 0 00011 1 abcd 0000
1 0 00010 2 99ff 0000
0 0 00010 3 0000 9934
0 0 00011 3 0000 56cd
0 0 60123 3 0000 4544
0 0 7da5a 3 0000 0100
1 1 07880 2 ab00 0000
1 1 07880 1 12cd 0000
0 1 07880 3 0000 abcd
1 1 00800 3 ffff 0000
0 1 00800 3 0000 0000
0 0 20010 3 0000 ffff
1 0 20010 3 dead ffff
1 0 60123 3 beef ffff
0 0 60123 3 0000 4544
0 0 00010 3 0000 9934

// File: src.f
soc_pkg.sv
bus_decoder.sv
flash_reader.sv
sram_arbiter.sv
response_combiner.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - files:
      - soc_pkg.sv
      - bus_decoder.sv
      - flash_reader.sv
      - sram_arbiter.sv
      - response_combiner.sv
      - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv
